// File: design/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Address of the first instruction fetched after reset
`define RESET_PC 32'h0000_0000

// Instruction queue depth in entries
`define FQ_DEPTH 4

// Occupancy counter width, must hold the value FQ_DEPTH
`define FQ_CNT_W 3

`endif

// File: design/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

    // HTRANS encodings
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_t;

    // HRESP encodings, AHB-Lite only has OKAY and ERROR
    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_t;

endpackage

`default_nettype wire

// File: design/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    // Major opcodes handled by the execute unit
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7 selecting SUB over ADD
    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

`default_nettype wire

// File: design/fetch_ahb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module fetch_ahb (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic [31:0]      i_hrdata,
    input  wire logic             i_hready,
    input  wire ahb_pkg::hresp_t  i_hresp,
    input  wire logic             i_fq_space,
    input  wire logic             i_redirect,
    input  wire logic [31:0]      i_redirect_pc,
    output logic [31:0]           o_haddr,
    output ahb_pkg::htrans_t      o_htrans,
    output logic                  o_push,
    output logic [31:0]           o_push_instr,
    output logic [31:0]           o_push_pc,
    output logic                  o_bus_error
);

    logic        run;
    logic [31:0] pc;
    logic        pending;
    logic        stale;
    logic [31:0] pending_addr;
    logic        can_issue;
    logic        accept;
    logic        live_done;

    // New address only when the previous data phase is done or finishing now
    // and is not answering ERROR
    assign can_issue = run && !o_bus_error && i_fq_space && !i_redirect
                       && (!pending || i_hready)
                       && !(pending && (i_hresp == ahb_pkg::HRESP_ERROR));
    assign accept    = can_issue && i_hready;

    // Completion of a data phase that still belongs to the current path
    assign live_done = pending && i_hready && !stale && !i_redirect;

    assign o_haddr      = pc;
    assign o_htrans     = can_issue ? ahb_pkg::HTRANS_NONSEQ : ahb_pkg::HTRANS_IDLE;
    assign o_push       = live_done && (i_hresp == ahb_pkg::HRESP_OKAY);
    assign o_push_instr = i_hrdata;
    assign o_push_pc    = pending_addr;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            run         <= 1'b0;
            pc          <= `RESET_PC;
            pending     <= 1'b0;
            stale       <= 1'b0;
            o_bus_error <= 1'b0;
        end else begin
            // Fetch starts one cycle out of reset
            run <= 1'b1;

            if (i_redirect) begin
                pc <= i_redirect_pc;
            end else if (accept) begin
                pc <= pc + 32'd4;
            end

            if (accept) begin
                pending <= 1'b1;
                stale   <= 1'b0;
            end else if (pending && i_hready) begin
                pending <= 1'b0;
                stale   <= 1'b0;
            end else if (i_redirect && pending) begin
                // Still waiting, so drop the word when it arrives
                stale <= 1'b1;
            end

            if (live_done && (i_hresp == ahb_pkg::HRESP_ERROR)) begin
                o_bus_error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pending_addr <= pc;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module fetch_queue (
    input  wire logic        clk,
    input  wire logic        reset_n,
    input  wire logic        i_push,
    input  wire logic [31:0] i_instr,
    input  wire logic [31:0] i_pc,
    input  wire logic        i_pop,
    input  wire logic        i_flush,
    output logic             o_valid,
    output logic [31:0]      o_instr,
    output logic [31:0]      o_pc,
    output logic             o_space
);

    localparam int PTR_W = (`FQ_DEPTH > 1) ? $clog2(`FQ_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`FQ_DEPTH - 1);

    logic [31:0]          instr_mem [`FQ_DEPTH];
    logic [31:0]          pc_mem    [`FQ_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [`FQ_CNT_W-1:0] count;
    logic                 do_push;
    logic                 do_pop;

    assign do_push = i_push && !i_flush && (count != `FQ_CNT_W'(`FQ_DEPTH));
    assign do_pop  = i_pop && o_valid;

    assign o_valid = (count != '0);
    assign o_instr = instr_mem[rd_ptr];
    assign o_pc    = pc_mem[rd_ptr];
    // One slot held back for the word still on the bus
    assign o_space = (count < `FQ_CNT_W'(`FQ_DEPTH - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            instr_mem[wr_ptr] <= i_instr;
            pc_mem[wr_ptr]    <= i_pc;
        end
    end

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic        clk,
    input  wire logic        reset_n,
    input  wire logic        i_valid,
    input  wire logic [31:0] i_instr,
    input  wire logic [31:0] i_pc,
    output logic             o_pop,
    output logic             o_redirect,
    output logic [31:0]      o_redirect_pc,
    output logic             o_retire_valid,
    output logic [31:0]      o_retire_pc,
    output logic [4:0]       o_retire_rd,
    output logic [31:0]      o_retire_value,
    output logic             o_retire_illegal
);

    logic [31:0]       regs [32];
    rv32_pkg::opcode_t opcode;
    rv32_pkg::alu_op_t alu_op;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [2:0]        funct3;
    logic [31:0]       rs1_val;
    logic [31:0]       rs2_val;
    logic [31:0]       imm_i;
    logic [31:0]       imm_u;
    logic [31:0]       imm_b;
    logic [31:0]       op_a;
    logic [31:0]       op_b;
    logic [31:0]       result;
    logic              legal;
    logic              is_branch;
    logic              taken;
    logic              wr_en;

    assign opcode = rv32_pkg::opcode_t'(i_instr[6:0]);
    assign rd     = i_instr[11:7];
    assign funct3 = i_instr[14:12];
    assign rs1    = i_instr[19:15];
    assign rs2    = i_instr[24:20];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};

    // x0 reads as zero
    assign rs1_val = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    // Decode
    always_comb begin
        alu_op    = rv32_pkg::ALU_ADD;
        legal     = 1'b1;
        is_branch = 1'b0;
        op_a      = rs1_val;
        op_b      = imm_i;
        case (opcode)
            rv32_pkg::OPC_OP, rv32_pkg::OPC_OP_IMM: begin
                if (opcode == rv32_pkg::OPC_OP) begin
                    op_b = rs2_val;
                end
                case (funct3)
                    rv32_pkg::F3_ADD: begin
                        if (opcode == rv32_pkg::OPC_OP && i_instr[31:25] == rv32_pkg::F7_SUB) begin
                            alu_op = rv32_pkg::ALU_SUB;
                        end
                    end
                    rv32_pkg::F3_SLT: alu_op = rv32_pkg::ALU_SLT;
                    rv32_pkg::F3_XOR: alu_op = rv32_pkg::ALU_XOR;
                    rv32_pkg::F3_OR:  alu_op = rv32_pkg::ALU_OR;
                    rv32_pkg::F3_AND: alu_op = rv32_pkg::ALU_AND;
                    // Shifts and SLTU are not implemented
                    default:          legal  = 1'b0;
                endcase
            end
            rv32_pkg::OPC_LUI: begin
                op_a = 32'd0;
                op_b = imm_u;
            end
            rv32_pkg::OPC_BRANCH: begin
                is_branch = 1'b1;
                legal     = (funct3 == rv32_pkg::F3_BEQ) || (funct3 == rv32_pkg::F3_BNE);
            end
            default: legal = 1'b0;
        endcase
    end

    // ALU
    always_comb begin
        case (alu_op)
            rv32_pkg::ALU_SUB: result = op_a - op_b;
            rv32_pkg::ALU_AND: result = op_a & op_b;
            rv32_pkg::ALU_OR:  result = op_a | op_b;
            rv32_pkg::ALU_XOR: result = op_a ^ op_b;
            rv32_pkg::ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
            default:           result = op_a + op_b;
        endcase
    end

    // BNE inverts the equality test
    assign taken = is_branch && legal
                   && ((rs1_val == rs2_val) ^ (funct3 == rv32_pkg::F3_BNE));
    assign wr_en = legal && !is_branch && (rd != 5'd0);

    assign o_pop         = i_valid;
    assign o_redirect    = i_valid && taken;
    assign o_redirect_pc = i_pc + imm_b;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_retire_valid <= 1'b0;
        end else begin
            o_retire_valid <= i_valid;
        end
    end

    // Register write and retire record land on the same edge
    always_ff @(posedge clk) begin
        if (i_valid) begin
            if (wr_en) begin
                regs[rd] <= result;
            end
            o_retire_pc      <= i_pc;
            o_retire_rd      <= wr_en ? rd : 5'd0;
            o_retire_value   <= wr_en ? result : 32'd0;
            o_retire_illegal <= !legal;
        end
    end

endmodule

`default_nettype wire

// File: design/rv32_fetch_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_fetch_core (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic [31:0]      i_hrdata,
    input  wire logic             i_hready,
    input  wire ahb_pkg::hresp_t  i_hresp,
    output logic [31:0]           o_haddr,
    output ahb_pkg::htrans_t      o_htrans,
    output logic                  o_bus_error,
    output logic                  o_retire_valid,
    output logic [31:0]           o_retire_pc,
    output logic [4:0]            o_retire_rd,
    output logic [31:0]           o_retire_value,
    output logic                  o_retire_illegal
);

    logic        push;
    logic [31:0] push_instr;
    logic [31:0] push_pc;
    logic        fq_space;
    logic        fq_valid;
    logic [31:0] fq_instr;
    logic [31:0] fq_pc;
    logic        pop;
    logic        redirect;
    logic [31:0] redirect_pc;

    fetch_ahb u_fetch (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_hrdata      (i_hrdata),
        .i_hready      (i_hready),
        .i_hresp       (i_hresp),
        .i_fq_space    (fq_space),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_haddr       (o_haddr),
        .o_htrans      (o_htrans),
        .o_push        (push),
        .o_push_instr  (push_instr),
        .o_push_pc     (push_pc),
        .o_bus_error   (o_bus_error)
    );

    // A taken branch flushes the queue in the cycle of its pop
    fetch_queue u_queue (
        .clk     (clk),
        .reset_n (reset_n),
        .i_push  (push),
        .i_instr (push_instr),
        .i_pc    (push_pc),
        .i_pop   (pop),
        .i_flush (redirect),
        .o_valid (fq_valid),
        .o_instr (fq_instr),
        .o_pc    (fq_pc),
        .o_space (fq_space)
    );

    exec_unit u_exec (
        .clk              (clk),
        .reset_n          (reset_n),
        .i_valid          (fq_valid),
        .i_instr          (fq_instr),
        .i_pc             (fq_pc),
        .o_pop            (pop),
        .o_redirect       (redirect),
        .o_redirect_pc    (redirect_pc),
        .o_retire_valid   (o_retire_valid),
        .o_retire_pc      (o_retire_pc),
        .o_retire_rd      (o_retire_rd),
        .o_retire_value   (o_retire_value),
        .o_retire_illegal (o_retire_illegal)
    );

endmodule

`default_nettype wire

// File: sim/ahb_rom_model.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_rom_model (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic [31:0]       i_haddr,
    input  wire ahb_pkg::htrans_t  i_htrans,
    input  wire logic [3:0]        i_max_wait,
    input  wire logic              i_err_en,
    input  wire logic [31:0]       i_err_addr,
    output logic [31:0]            o_hrdata,
    output logic                   o_hready,
    output ahb_pkg::hresp_t        o_hresp
);

    logic [31:0] mem [64];
    logic        busy;
    logic        err;
    logic [3:0]  wait_left;
    logic [31:0] addr_q;
    integer      seed = 32'hd36d_25fb;

    assign o_hready = !busy || (wait_left == 4'd0);
    // Two-cycle ERROR response with HREADY low in the first cycle
    assign o_hresp  = (busy && err && (wait_left <= 4'd1)) ? ahb_pkg::HRESP_ERROR
                                                           : ahb_pkg::HRESP_OKAY;
    assign o_hrdata = (busy && !err) ? mem[addr_q[7:2]] : 32'd0;

    always @(posedge clk or negedge reset_n) begin : data_phase
        logic [3:0] waits;
        if (!reset_n) begin
            busy      <= 1'b0;
            err       <= 1'b0;
            wait_left <= 4'd0;
            addr_q    <= 32'd0;
        end else if (o_hready) begin
            busy <= (i_htrans == ahb_pkg::HTRANS_NONSEQ);
            if (i_htrans == ahb_pkg::HTRANS_NONSEQ) begin
                waits = 4'd0;
                if (i_max_wait != 4'd0) begin
                    waits = 4'($unsigned($random(seed)) % (i_max_wait + 32'd1));
                end
                // Only the error address answers ERROR
                if (i_err_en && (i_haddr == i_err_addr) && (waits == 4'd0)) begin
                    waits = 4'd1;
                end
                wait_left <= waits;
                err       <= i_err_en && (i_haddr == i_err_addr);
                addr_q    <= i_haddr;
            end
        end else begin
            wait_left <= wait_left - 4'd1;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_rv32_fetch_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tb_rv32_fetch_core;

    localparam int ROM_WORDS = 64;
    localparam logic [31:0] NO_STOP = 32'hffff_ffff;

    logic             clk;
    logic             reset_n;
    logic [31:0]      hrdata;
    logic             hready;
    ahb_pkg::hresp_t  hresp;
    logic [31:0]      haddr;
    ahb_pkg::htrans_t htrans;
    logic             bus_error;
    logic             retire_valid;
    logic [31:0]      retire_pc;
    logic [4:0]       retire_rd;
    logic [31:0]      retire_value;
    logic             retire_illegal;
    logic [3:0]       max_wait;
    logic             err_en;
    logic [31:0]      err_addr;

    logic [31:0] prog [ROM_WORDS];
    int          prog_len;
    int          errors;
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_value [$];
    logic        exp_illegal [$];

    rv32_fetch_core dut0 (
        .clk              (clk),
        .reset_n          (reset_n),
        .i_hrdata         (hrdata),
        .i_hready         (hready),
        .i_hresp          (hresp),
        .o_haddr          (haddr),
        .o_htrans         (htrans),
        .o_bus_error      (bus_error),
        .o_retire_valid   (retire_valid),
        .o_retire_pc      (retire_pc),
        .o_retire_rd      (retire_rd),
        .o_retire_value   (retire_value),
        .o_retire_illegal (retire_illegal)
    );

    ahb_rom_model rom0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_haddr    (haddr),
        .i_htrans   (htrans),
        .i_max_wait (max_wait),
        .i_err_en   (err_en),
        .i_err_addr (err_addr),
        .o_hrdata   (hrdata),
        .o_hready   (hready),
        .o_hresp    (hresp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv32_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input int imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, rv32_pkg::OPC_LUI};
    endfunction

    // B-type immediate is scrambled across the word
    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input int off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv32_pkg::OPC_BRANCH};
    endfunction

    task automatic clear_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            // Unused words decode as illegal and carry their own index
            prog[i] = {25'(i), 7'h7f};
        end
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] instr);
        prog[prog_len] = instr;
        prog_len++;
    endtask

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom0.mem[i] = prog[i];
        end
    endtask

    task automatic build_straight();
        clear_program();
        emit(enc_lui(5'd1, 20'h12345));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd1, 5'd1, 'h678));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd2, 5'd0, -5));
        emit(enc_r(7'd0, rv32_pkg::F3_ADD, 5'd3, 5'd1, 5'd2));
        emit(enc_r(rv32_pkg::F7_SUB, rv32_pkg::F3_ADD, 5'd4, 5'd2, 5'd1));
        emit(enc_r(7'd0, rv32_pkg::F3_AND, 5'd5, 5'd1, 5'd3));
        emit(enc_r(7'd0, rv32_pkg::F3_OR, 5'd6, 5'd4, 5'd2));
        emit(enc_r(7'd0, rv32_pkg::F3_XOR, 5'd7, 5'd6, 5'd1));
        // Negative against positive, both orders
        emit(enc_r(7'd0, rv32_pkg::F3_SLT, 5'd8, 5'd2, 5'd1));
        emit(enc_r(7'd0, rv32_pkg::F3_SLT, 5'd9, 5'd1, 5'd2));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_SLT, 5'd10, 5'd2, -3));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_AND, 5'd11, 5'd7, 'hff));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_OR, 5'd12, 5'd11, -16));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_XOR, 5'd13, 5'd12, 'h555));
        // Write to x0, then read x0 back
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd0, 5'd1, 7));
        emit(enc_r(7'd0, rv32_pkg::F3_ADD, 5'd14, 5'd0, 5'd13));
        emit(enc_b(rv32_pkg::F3_BEQ, 5'd0, 5'd0, 0));
    endtask

    task automatic build_branches();
        clear_program();
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd1, 5'd0, 3));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd2, 5'd0, 0));
        // Loop body at 0x08, runs three times
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd2, 5'd2, 10));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd1, 5'd1, -1));
        emit(enc_b(rv32_pkg::F3_BNE, 5'd1, 5'd0, -8));
        // Forward jump over two words
        emit(enc_b(rv32_pkg::F3_BEQ, 5'd1, 5'd0, 12));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd3, 5'd0, 99));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd4, 5'd0, 99));
        emit(enc_b(rv32_pkg::F3_BEQ, 5'd2, 5'd0, 8));
        emit(enc_b(rv32_pkg::F3_BNE, 5'd2, 5'd2, 8));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd5, 5'd2, 1));
        emit(enc_b(rv32_pkg::F3_BEQ, 5'd0, 5'd0, 0));
    endtask

    task automatic build_illegal();
        clear_program();
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd1, 5'd0, 5));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd2, 5'd0, -1));
        // Unknown opcodes aimed at live registers
        emit(enc_i(7'b0001011, 3'b000, 5'd1, 5'd2, 'h123));
        emit(enc_i(7'b1111111, 3'b000, 5'd2, 5'd1, -1));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd3, 5'd1, 0));
        emit(enc_i(rv32_pkg::OPC_OP_IMM, rv32_pkg::F3_ADD, 5'd4, 5'd2, 0));
        emit(enc_b(rv32_pkg::F3_BEQ, 5'd0, 5'd0, 0));
    endtask

    // Instruction-level model; stops at stop_pc or after a branch to itself
    task automatic ref_model(input logic [31:0] stop_pc);
        logic [31:0] rf [32];
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] next_pc;
        logic        wr;
        logic        ill;
        logic        done;
        int          steps;
        exp_pc.delete();
        exp_rd.delete();
        exp_value.delete();
        exp_illegal.delete();
        foreach (rf[i]) begin
            rf[i] = 32'd0;
        end
        pc = `RESET_PC;
        done = 1'b0;
        steps = 0;
        while (!done && (pc != stop_pc) && (steps < 256)) begin
            instr = prog[pc[7:2]];
            a = rf[instr[19:15]];
            b = rf[instr[24:20]];
            val = 32'd0;
            wr = 1'b0;
            ill = 1'b0;
            next_pc = pc + 32'd4;
            case (instr[6:0])
                rv32_pkg::OPC_LUI: begin
                    wr = 1'b1;
                    val = {instr[31:12], 12'd0};
                end
                rv32_pkg::OPC_OP, rv32_pkg::OPC_OP_IMM: begin
                    if (instr[6:0] == rv32_pkg::OPC_OP_IMM) begin
                        b = {{20{instr[31]}}, instr[31:20]};
                    end
                    wr = 1'b1;
                    case (instr[14:12])
                        rv32_pkg::F3_ADD: begin
                            if (instr[6:0] == rv32_pkg::OPC_OP && instr[31:25] == rv32_pkg::F7_SUB)
                                val = a - b;
                            else
                                val = a + b;
                        end
                        rv32_pkg::F3_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        rv32_pkg::F3_XOR: val = a ^ b;
                        rv32_pkg::F3_OR:  val = a | b;
                        rv32_pkg::F3_AND: val = a & b;
                        default: begin
                            wr = 1'b0;
                            ill = 1'b1;
                        end
                    endcase
                end
                rv32_pkg::OPC_BRANCH: begin
                    if (instr[14:12] != rv32_pkg::F3_BEQ && instr[14:12] != rv32_pkg::F3_BNE) begin
                        ill = 1'b1;
                    end else if ((a == b) == (instr[14:12] == rv32_pkg::F3_BEQ)) begin
                        next_pc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                    end
                end
                default: ill = 1'b1;
            endcase
            if (wr && instr[11:7] != 5'd0) begin
                rf[instr[11:7]] = val;
                exp_rd.push_back(instr[11:7]);
                exp_value.push_back(val);
            end else begin
                exp_rd.push_back(5'd0);
                exp_value.push_back(32'd0);
            end
            exp_pc.push_back(pc);
            exp_illegal.push_back(ill);
            done = (next_pc == pc);
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic reset_core();
        @(posedge clk);
        reset_n <= 1'b0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    task automatic collect_retires(input string name);
        int cycles;
        int idx;
        cycles = 0;
        idx = 0;
        while (idx < exp_pc.size() && cycles < 2000) begin
            @(negedge clk);
            cycles++;
            if (retire_valid) begin
                check("o_retire_pc", retire_pc, exp_pc[idx]);
                check("o_retire_rd", 32'(retire_rd), 32'(exp_rd[idx]));
                check("o_retire_value", retire_value, exp_value[idx]);
                check("o_retire_illegal", 32'(retire_illegal), 32'(exp_illegal[idx]));
                idx++;
            end
        end
        if (idx < exp_pc.size()) begin
            $display("Timeout in %s: only %0d of %0d instructions retired",
                     name, idx, exp_pc.size());
            errors++;
        end
    endtask

    task automatic run_program(input string name, input logic [3:0] waits,
                               input logic use_err, input logic [31:0] bad_addr);
        load_program();
        @(posedge clk);
        max_wait <= waits;
        err_en   <= use_err;
        err_addr <= bad_addr;
        ref_model(use_err ? bad_addr : NO_STOP);
        reset_core();
        collect_retires(name);
        if (!use_err) begin
            check("o_bus_error", 32'(bus_error), 32'd0);
        end
    endtask

    task automatic test_reset();
        int cycles;
        build_straight();
        load_program();
        @(posedge clk);
        reset_n  <= 1'b0;
        max_wait <= 4'd0;
        err_en   <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check("o_htrans", 32'(htrans), 32'(ahb_pkg::HTRANS_IDLE));
            check("o_retire_valid", 32'(retire_valid), 32'd0);
            check("o_bus_error", 32'(bus_error), 32'd0);
        end
        @(posedge clk);
        reset_n <= 1'b1;
        cycles = 0;
        while (htrans != ahb_pkg::HTRANS_NONSEQ && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (htrans != ahb_pkg::HTRANS_NONSEQ) begin
            $display("Timeout: no fetch was issued after reset");
            errors++;
        end else begin
            check("o_haddr", haddr, `RESET_PC);
        end
    endtask

    task automatic test_straight(input logic [3:0] waits);
        build_straight();
        run_program("straight-line code", waits, 1'b0, 32'd0);
    endtask

    task automatic test_branches(input logic [3:0] waits);
        build_branches();
        run_program("branches", waits, 1'b0, 32'd0);
    endtask

    task automatic test_bus_error();
        int cycles;
        int stray;
        build_straight();
        run_program("bus error", 4'd0, 1'b1, 32'h0000_0014);
        cycles = 0;
        while (!bus_error && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (!bus_error) begin
            $display("Timeout: bus error flag never rose");
            errors++;
        end
        stray = 0;
        repeat (30) begin
            @(negedge clk);
            if (retire_valid) begin
                stray++;
            end
            check("o_bus_error", 32'(bus_error), 32'd1);
        end
        if (stray != 0) begin
            $display("Instructions kept retiring after the bus error: %0d seen", stray);
            errors++;
        end
    endtask

    task automatic test_illegal();
        build_illegal();
        run_program("illegal opcode", 4'd0, 1'b0, 32'd0);
    endtask

    initial begin
        reset_n  = 1'b0;
        max_wait = 4'd0;
        err_en   = 1'b0;
        err_addr = 32'd0;
        errors   = 0;
        prog_len = 0;
        test_reset();
        test_straight(4'd0);
        test_branches(4'd0);
        // Same programs with random HREADY stalls
        test_straight(4'd3);
        test_branches(4'd3);
        test_bus_error();
        test_illegal();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
design/ahb_pkg.sv
design/rv32_pkg.sv
design/fetch_ahb.sv
design/fetch_queue.sv
design/exec_unit.sv
design/rv32_fetch_core.sv
sim/ahb_rom_model.sv
sim/tb_rv32_fetch_core.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary -Wno-fatal --top-module tb_rv32_fetch_core -f all.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
